/* flist.f */
+incdir+hdl
hdl/backend_ctrl_pkg.sv
hdl/backend_data_pkg.sv
hdl/forwarding_mux.sv
hdl/exec_alu.sv
hdl/ex_stage.sv
hdl/mem_wb_stages.sv
hdl/backend_pipeline.sv
verification/backend_pipeline_assertions.sv
verification/backend_pipeline_tb.sv

/* run_sim.sh */
#!/bin/bash
# compile and run the backend pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f flist.f \
	--top-module backend_pipeline_tb \
	-o backend_sim

# keep going on a nonzero exit so the log can be searched
./obj_dir/backend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
	echo "no pass message in sim.log"
	exit 1
fi

exit 0

/* verification/backend_pipeline_tb.sv */
`timescale 1ns/100ps

module backend_pipeline_tb;

	logic                            clk = 1'b0;
	logic                            rst_n = 1'b0;
	logic                            issue = 1'b0;
	backend_ctrl_pkg::alu_op_e       op = backend_ctrl_pkg::ALU_ADD;
	backend_ctrl_pkg::wb_sel_e       wb_sel = backend_ctrl_pkg::WB_ALU;
	backend_data_pkg::reg_addr_t     rd = '0;
	backend_data_pkg::word_t         pc = '0;
	logic                            revert = 1'b0;
	backend_data_pkg::word_t         rj = '0;
	backend_data_pkg::word_t         rk = '0;
	backend_ctrl_pkg::fwd_stage_e    fwd_stage [2] = '{backend_ctrl_pkg::FWD_NONE,
		backend_ctrl_pkg::FWD_NONE};
	logic [1:0]                      fwd_pipe = '0;
	logic [2:0]                      stall = '0; // ex, m1, m2
	logic [2:0]                      clr = '0;
	backend_data_pkg::fwd_src_t      fwd_src = '0;
	backend_data_pkg::reg_addr_t     reg_w_addr;
	backend_data_pkg::word_t         reg_w_data;
	backend_data_pkg::word_t [2:0]   fwd_data;
	logic [3:0]                      revert_vec;

	// model state of ex and of the m1, m2, wb slots
	logic                            ex_v = 0;
	logic                            ex_rv = 0;
	logic [4:0]                      ex_rd = 0;
	backend_ctrl_pkg::alu_op_e       ex_op = backend_ctrl_pkg::ALU_ADD;
	backend_ctrl_pkg::wb_sel_e       ex_ws = backend_ctrl_pkg::WB_ALU;
	logic [31:0]                     ex_pc;
	logic [31:0]                     ex_opnd [2];
	backend_ctrl_pkg::fwd_stage_e    ex_sel [2] = '{backend_ctrl_pkg::FWD_NONE,
		backend_ctrl_pkg::FWD_NONE};
	logic [1:0]                      ex_pipe = 0;
	logic [2:0]                      mw_v = 0;
	logic [2:0]                      mw_rv = 0;
	logic [4:0]                      mw_rd [3] = '{0, 0, 0};
	logic [31:0]                     mw_res [3];

	backend_pipeline dut0 (
		.clk(clk), .rst_n(rst_n), .issue_i(issue), .op_i(op), .wb_sel_i(wb_sel),
		.rd_i(rd), .pc_i(pc), .revert_i(revert), .rj_i(rj), .rk_i(rk),
		.fwd_stage_i(fwd_stage), .fwd_pipe_i(fwd_pipe), .stall_i(stall), .clr_i(clr),
		.fwd_src_i(fwd_src), .reg_w_addr_o(reg_w_addr), .reg_w_data_o(reg_w_data),
		.forwarding_data_o(fwd_data), .revert_vector_o(revert_vec)
	);

	always #50 clk = ~clk;

	// expected ALU or link value from the opcode definitions
	function automatic logic [31:0] alu_ref(input backend_ctrl_pkg::alu_op_e o,
		input backend_ctrl_pkg::wb_sel_e ws, input logic [31:0] a, b, p);
		logic [63:0] ext;
		if (ws == backend_ctrl_pkg::WB_LINK) return p + 32'd4;
		ext = {{32{a[31]}}, a};
		case (o)
			backend_ctrl_pkg::ALU_ADD:  return a + b;
			backend_ctrl_pkg::ALU_SUB:  return a + ~b + 32'd1;
			backend_ctrl_pkg::ALU_AND:  return a & b;
			backend_ctrl_pkg::ALU_OR:   return a | b;
			backend_ctrl_pkg::ALU_XOR:  return a ^ b;
			backend_ctrl_pkg::ALU_SLL:  return a << b[4:0];
			backend_ctrl_pkg::ALU_SRL:  return a >> b[4:0];
			backend_ctrl_pkg::ALU_SRA:  return 32'(ext >> b[4:0]);
			backend_ctrl_pkg::ALU_SLT:  return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
			backend_ctrl_pkg::ALU_SLTU: return {31'd0, a < b};
			default:                    return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] fwd_pick(input backend_ctrl_pkg::fwd_stage_e s,
		input logic p, input logic [31:0] old);
		case (s)
			backend_ctrl_pkg::FWD_M1: return fwd_src[p][0];
			backend_ctrl_pkg::FWD_M2: return fwd_src[p][1];
			backend_ctrl_pkg::FWD_WB: return fwd_src[p][2];
			default:                  return old;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, got);
		assert (got === exp) else begin
			$display("[FAIL] time %0t %s expected %h got %h", $time, name, exp, got);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// state after the coming rising edge, from the inputs it will sample
	task automatic model_step();
		logic [31:0] f [2];
		logic [3:0]  st;
		for (int i = 0; i < 2; i++) begin
			f[i] = fwd_pick(ex_sel[i], ex_pipe[i], ex_opnd[i]);
		end
		st = {1'b0, stall};
		for (int s = 2; s >= 0; s--) begin
			if (!rst_n) begin
				mw_v[s]  = 0;
				mw_rv[s] = 0;
				mw_rd[s] = 0;
			end else if (!st[s+1]) begin
				mw_res[s] = (s == 0) ? alu_ref(ex_op, ex_ws, f[0], f[1], ex_pc) : mw_res[s-1];
				if (st[s] || clr[s]) begin
					mw_v[s]  = 0; // bubble
					mw_rv[s] = 0;
					mw_rd[s] = 0;
				end else begin
					mw_v[s]  = (s == 0) ? ex_v : mw_v[s-1];
					mw_rv[s] = (s == 0) ? ex_rv : mw_rv[s-1];
					mw_rd[s] = (s == 0) ? ex_rd : mw_rd[s-1];
				end
			end
		end
		if (!rst_n || !stall[0]) begin
			ex_v       = rst_n && issue;
			ex_rv      = ex_v && revert;
			ex_rd      = ex_v ? rd : 5'd0;
			ex_op      = op;
			ex_ws      = wb_sel;
			ex_pc      = pc;
			ex_pipe    = fwd_pipe;
			ex_opnd[0] = rj;
			ex_opnd[1] = rk;
			for (int i = 0; i < 2; i++) begin
				ex_sel[i] = ex_v ? fwd_stage[i] : backend_ctrl_pkg::FWD_NONE;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				ex_opnd[i] = f[i];
				case (ex_sel[i])
					backend_ctrl_pkg::FWD_M1: if (!stall[1]) ex_sel[i] = backend_ctrl_pkg::FWD_M2;
					backend_ctrl_pkg::FWD_M2: if (!stall[2]) ex_sel[i] = backend_ctrl_pkg::FWD_WB;
					backend_ctrl_pkg::FWD_WB: ex_sel[i] = backend_ctrl_pkg::FWD_NONE;
					default: ;
				endcase
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		check_val("reg_w_addr_o", {27'd0, mw_v[2] ? mw_rd[2] : 5'd0}, {27'd0, reg_w_addr});
		if (mw_v[2]) check_val("reg_w_data_o", mw_res[2], reg_w_data);
		for (int s = 0; s < 3; s++) begin
			if (mw_v[s]) begin
				check_val($sformatf("forwarding_data_o[%0d]", s), mw_res[s], fwd_data[s]);
			end
		end
		check_val("revert_vector_o", {28'd0, mw_rv[2], mw_rv[1], mw_rv[0], ex_rv},
			{28'd0, revert_vec});
		model_step();
	end

	task automatic drive(input logic [2:0] st, cl, input bit fwd_on, new_src);
		@(posedge clk);
		issue  <= $urandom_range(0, 3) != 0;
		op     <= backend_ctrl_pkg::alu_op_e'($urandom_range(0, 9));
		wb_sel <= backend_ctrl_pkg::wb_sel_e'($urandom_range(0, 7) == 0);
		rd     <= 5'($urandom);
		pc     <= $urandom;
		rj     <= $urandom;
		rk     <= $urandom;
		revert <= 1'($urandom);
		fwd_pipe <= 2'($urandom);
		for (int i = 0; i < 2; i++)
			fwd_stage[i] <= fwd_on ? backend_ctrl_pkg::fwd_stage_e'($urandom_range(0, 3))
				: backend_ctrl_pkg::FWD_NONE;
		if (new_src) begin
			for (int k = 0; k < 6; k++) begin
				fwd_src[k/3][k%3] <= $urandom;
			end
		end
		stall <= st;
		clr   <= cl;
	endtask

	function automatic logic [2:0] mono_stall();
		case ($urandom_range(0, 5))
			0: return 3'b001;
			1: return 3'b011;
			2: return 3'b111;
			default: return 3'b000;
		endcase
	endfunction

	initial begin
		int cnt;
		void'($urandom(5));
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (60) drive(3'b000, 3'b000, 0, 0); // back to back without stalls
		for (int k = 0; k < 6; k++) fwd_src[k/3][k%3] <= 32'h1000_0000 * (k + 1) + k;
		repeat (40) drive(3'b000, 3'b000, 1, 0); // constant forwarding words
		for (int r = 0; r < 10; r++) begin
			drive(3'b000, 3'b000, 1, 1);
			fwd_stage[0] <= backend_ctrl_pkg::FWD_M1; // ex stalled on an m1 producer
			repeat (3) drive(3'b001, 3'b000, 1, 1);
		end
		repeat (30) drive(3'b111, 3'b000, 1, 1); // everything held
		repeat (150) drive(mono_stall(), 3'b000, 1, 1);
		repeat (150) drive(mono_stall(), 3'($urandom_range(0, 7) == 0 ? $urandom : 0), 1, 1);
		drive(3'b000, 3'b000, 0, 0);
		issue <= 1'b0;
		cnt = 0;
		while ((ex_v || mw_v != 0) && cnt < 20) begin
			@(posedge clk);
			cnt++;
		end
		if (ex_v || mw_v != 0) begin
			$display("pipeline did not drain within 20 cycles");
			$display("Simulation FAILED");
			$fatal(1, "drain timeout");
		end else begin
			repeat (2) @(posedge clk);
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule : backend_pipeline_tb

/* verification/backend_pipeline_assertions.sv */
`timescale 1ns/100ps
`include "backend_settings.svh"

module backend_pipeline_assertions (
	input logic                          clk,
	input logic                          rst_n,
	input logic [`BK_STAGE_NUM-2:0]      stall_i,
	input logic [`BK_STAGE_NUM-2:0]      clr_i,
	input backend_data_pkg::reg_addr_t   reg_w_addr_o,
	input logic [`BK_STAGE_NUM-1:0]      revert_vector_o
);

	// no write right after reset
	a_rst_addr: assert property (@(posedge clk) !rst_n |=> reg_w_addr_o == '0)
		else $error("write address not zero after reset");

	// wb takes a bubble when m2 is cleared
	a_clr_m2: assert property (@(posedge clk) rst_n && clr_i[2] |=> reg_w_addr_o == '0)
		else $error("write after m2 clear");

	// held ex keeps its revert flag
	a_ex_revert: assert property (@(posedge clk)
		rst_n && stall_i[0] ##1 rst_n |-> revert_vector_o[0] == $past(revert_vector_o[0]))
		else $error("ex revert changed while stalled");

endmodule : backend_pipeline_assertions

bind backend_pipeline backend_pipeline_assertions u_assertions (
	.clk             (clk),
	.rst_n           (rst_n),
	.stall_i         (stall_i),
	.clr_i           (clr_i),
	.reg_w_addr_o    (reg_w_addr_o),
	.revert_vector_o (revert_vector_o)
);

/* hdl/backend_pipeline.sv */
`timescale 1ns/100ps
`include "backend_settings.svh"

module backend_pipeline (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic                                           issue_i,
	input  backend_ctrl_pkg::alu_op_e                      op_i,
	input  backend_ctrl_pkg::wb_sel_e                      wb_sel_i,
	input  backend_data_pkg::reg_addr_t                    rd_i,
	input  backend_data_pkg::word_t                        pc_i,
	input  logic                                           revert_i,
	input  backend_data_pkg::word_t                        rj_i,
	input  backend_data_pkg::word_t                        rk_i,
	input  backend_ctrl_pkg::fwd_stage_e                   fwd_stage_i [2], // rj, rk
	input  logic [1:0]                                     fwd_pipe_i,
	input  logic [`BK_STAGE_NUM-2:0]                       stall_i, // ex, m1, m2
	input  logic [`BK_STAGE_NUM-2:0]                       clr_i,
	input  backend_data_pkg::fwd_src_t                     fwd_src_i,
	output backend_data_pkg::reg_addr_t                    reg_w_addr_o,
	output backend_data_pkg::word_t                        reg_w_data_o,
	output backend_data_pkg::word_t [`BK_FWD_STAGE_NUM-1:0] forwarding_data_o,
	output logic [`BK_STAGE_NUM-1:0]                       revert_vector_o // wb, m2, m1, ex
);

	backend_data_pkg::word_t             ex_result;
	backend_data_pkg::reg_addr_t         ex_rd;
	logic                                ex_revert;
	logic                                ex_valid;
	logic [`BK_FWD_STAGE_NUM-1:0]        mw_revert;

	ex_stage u_ex_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_i     (issue_i),
		.stall_i     (stall_i[0]),
		.adv_m1_i    (~stall_i[1]),
		.adv_m2_i    (~stall_i[2]),
		.op_i        (op_i),
		.wb_sel_i    (wb_sel_i),
		.rd_i        (rd_i),
		.pc_i        (pc_i),
		.revert_i    (revert_i),
		.rj_i        (rj_i),
		.rk_i        (rk_i),
		.fwd_stage_i (fwd_stage_i),
		.fwd_pipe_i  (fwd_pipe_i),
		.fwd_src_i   (fwd_src_i),
		.result_o    (ex_result),
		.rd_o        (ex_rd),
		.revert_o    (ex_revert),
		.valid_o     (ex_valid)
	);

	mem_wb_stages u_mem_wb (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall_i      (stall_i),
		.clr_i        (clr_i),
		.ex_result_i  (ex_result),
		.ex_rd_i      (ex_rd),
		.ex_revert_i  (ex_revert),
		.ex_valid_i   (ex_valid),
		.reg_w_addr_o (reg_w_addr_o),
		.reg_w_data_o (reg_w_data_o),
		.fwd_data_o   (forwarding_data_o),
		.revert_o     (mw_revert)
	);

	assign revert_vector_o = {mw_revert, ex_revert};

endmodule : backend_pipeline

/* hdl/mem_wb_stages.sv */
`timescale 1ns/100ps
`include "backend_settings.svh"

module mem_wb_stages (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic [`BK_STAGE_NUM-2:0]                       stall_i, // ex, m1, m2
	input  logic [`BK_STAGE_NUM-2:0]                       clr_i,   // ex, m1, m2
	input  backend_data_pkg::word_t                        ex_result_i,
	input  backend_data_pkg::reg_addr_t                    ex_rd_i,
	input  logic                                           ex_revert_i,
	input  logic                                           ex_valid_i,
	output backend_data_pkg::reg_addr_t                    reg_w_addr_o,
	output backend_data_pkg::word_t                        reg_w_data_o,
	output backend_data_pkg::word_t [`BK_FWD_STAGE_NUM-1:0] fwd_data_o,
	output logic [`BK_FWD_STAGE_NUM-1:0]                   revert_o
);

	// stage index 0 is m1, 1 is m2, 2 is wb
	logic [`BK_STAGE_NUM-1:0]                              stall_all;
	logic [`BK_FWD_STAGE_NUM-1:0]                          valid_q;
	logic [`BK_FWD_STAGE_NUM-1:0]                          revert_q;
	backend_data_pkg::reg_addr_t [`BK_FWD_STAGE_NUM-1:0]   rd_q;
	backend_data_pkg::word_t [`BK_FWD_STAGE_NUM-1:0]       result_q;

	// what each stage sees from the one before it
	logic [`BK_FWD_STAGE_NUM-1:0]                          up_valid;
	logic [`BK_FWD_STAGE_NUM-1:0]                          up_revert;
	backend_data_pkg::reg_addr_t [`BK_FWD_STAGE_NUM-1:0]   up_rd;
	backend_data_pkg::word_t [`BK_FWD_STAGE_NUM-1:0]       up_result;

	assign stall_all = {1'b0, stall_i}; // wb never stalls

	assign up_valid  = {valid_q[`BK_FWD_STAGE_NUM-2:0], ex_valid_i};
	assign up_revert = {revert_q[`BK_FWD_STAGE_NUM-2:0], ex_revert_i};
	assign up_rd     = {rd_q[`BK_FWD_STAGE_NUM-2:0], ex_rd_i};
	assign up_result = {result_q[`BK_FWD_STAGE_NUM-2:0], ex_result_i};

	// a stage takes a bubble when its source is stalled or cleared
	always_ff @(posedge clk) begin
		for (int s = 0; s < `BK_FWD_STAGE_NUM; s++) begin
			if (!rst_n) begin
				valid_q[s]  <= 1'b0;
				revert_q[s] <= 1'b0;
				rd_q[s]     <= '0;
			end else if (!stall_all[s+1]) begin
				if (stall_all[s] || clr_i[s]) begin
					valid_q[s]  <= 1'b0;
					revert_q[s] <= 1'b0;
					rd_q[s]     <= '0;
				end else begin
					valid_q[s]  <= up_valid[s];
					revert_q[s] <= up_revert[s];
					rd_q[s]     <= up_rd[s];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < `BK_FWD_STAGE_NUM; s++) begin
			if (!stall_all[s+1]) begin
				result_q[s] <= up_result[s];
			end
		end
	end

	assign reg_w_addr_o = valid_q[`BK_FWD_STAGE_NUM-1] ? rd_q[`BK_FWD_STAGE_NUM-1] : '0;
	assign reg_w_data_o = result_q[`BK_FWD_STAGE_NUM-1];
	assign fwd_data_o   = result_q; // m1, m2, wb results
	assign revert_o     = revert_q;

endmodule : mem_wb_stages

/* hdl/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_i,
	input  logic                         stall_i,
	input  logic                         adv_m1_i,
	input  logic                         adv_m2_i,
	input  backend_ctrl_pkg::alu_op_e    op_i,
	input  backend_ctrl_pkg::wb_sel_e    wb_sel_i,
	input  backend_data_pkg::reg_addr_t  rd_i,
	input  backend_data_pkg::word_t      pc_i,
	input  logic                         revert_i,
	input  backend_data_pkg::word_t      rj_i,
	input  backend_data_pkg::word_t      rk_i,
	input  backend_ctrl_pkg::fwd_stage_e fwd_stage_i [2],
	input  logic [1:0]                   fwd_pipe_i,
	input  backend_data_pkg::fwd_src_t   fwd_src_i,
	output backend_data_pkg::word_t      result_o,
	output backend_data_pkg::reg_addr_t  rd_o,
	output logic                         revert_o,
	output logic                         valid_o
);

	// control registers
	logic                         valid_q;
	logic                         revert_q;
	backend_ctrl_pkg::alu_op_e    op_q;
	backend_ctrl_pkg::wb_sel_e    wb_sel_q;
	backend_data_pkg::reg_addr_t  rd_q;
	backend_ctrl_pkg::fwd_stage_e fwd_stage_q [2];
	logic [1:0]                   fwd_pipe_q;

	// data registers
	backend_data_pkg::word_t pc_q;
	backend_data_pkg::word_t opnd_q [2];   // index 0 rj, 1 rk
	backend_data_pkg::word_t opnd_fwd [2]; // after forwarding

	// follows the producer as it moves down the other pipe
	function automatic backend_ctrl_pkg::fwd_stage_e retarget(
		input backend_ctrl_pkg::fwd_stage_e cur,
		input logic                         adv_m1,
		input logic                         adv_m2
	);
		backend_ctrl_pkg::fwd_stage_e nxt;
		nxt = cur;
		case (cur)
			backend_ctrl_pkg::FWD_M1: begin
				if (adv_m1) begin
					nxt = backend_ctrl_pkg::FWD_M2;
				end
			end
			backend_ctrl_pkg::FWD_M2: begin
				if (adv_m2) begin
					nxt = backend_ctrl_pkg::FWD_WB;
				end
			end
			backend_ctrl_pkg::FWD_WB: begin
				nxt = backend_ctrl_pkg::FWD_NONE; // value already captured
			end
			default: begin
				nxt = cur;
			end
		endcase
		return nxt;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n || (!stall_i && !issue_i)) begin
			valid_q    <= 1'b0; // bubble
			revert_q   <= 1'b0;
			op_q       <= backend_ctrl_pkg::ALU_ADD;
			wb_sel_q   <= backend_ctrl_pkg::WB_ALU;
			rd_q       <= '0;
			fwd_pipe_q <= '0;
			for (int i = 0; i < 2; i++) begin
				fwd_stage_q[i] <= backend_ctrl_pkg::FWD_NONE;
			end
		end else if (!stall_i) begin
			valid_q    <= 1'b1;
			revert_q   <= revert_i;
			op_q       <= op_i;
			wb_sel_q   <= wb_sel_i;
			rd_q       <= rd_i;
			fwd_pipe_q <= fwd_pipe_i;
			for (int i = 0; i < 2; i++) begin
				fwd_stage_q[i] <= fwd_stage_i[i];
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				fwd_stage_q[i] <= retarget(fwd_stage_q[i], adv_m1_i, adv_m2_i);
			end
		end
	end

	// while stalled the operands keep whatever the muxes deliver
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			pc_q      <= pc_i;
			opnd_q[0] <= rj_i;
			opnd_q[1] <= rk_i;
		end else begin
			opnd_q <= opnd_fwd;
		end
	end

	for (genvar i = 0; i < 2; i++) begin : g_fwd
		forwarding_mux u_fwd_mux (
			.sel_i  (fwd_stage_q[i]),
			.pipe_i (fwd_pipe_q[i]),
			.src_i  (fwd_src_i),
			.old_i  (opnd_q[i]),
			.data_o (opnd_fwd[i])
		);
	end

	exec_alu u_alu (
		.op_i     (op_q),
		.wb_sel_i (wb_sel_q),
		.a_i      (opnd_fwd[0]),
		.b_i      (opnd_fwd[1]),
		.pc_i     (pc_q),
		.result_o (result_o)
	);

	assign rd_o     = rd_q;
	assign revert_o = revert_q;
	assign valid_o  = valid_q;

endmodule : ex_stage

/* hdl/exec_alu.sv */
`timescale 1ns/100ps

module exec_alu (
	input  backend_ctrl_pkg::alu_op_e op_i,
	input  backend_ctrl_pkg::wb_sel_e wb_sel_i,
	input  backend_data_pkg::word_t   a_i,
	input  backend_data_pkg::word_t   b_i,
	input  backend_data_pkg::word_t   pc_i,
	output backend_data_pkg::word_t   result_o
);

	backend_data_pkg::word_t alu_res;
	backend_data_pkg::word_t link_res;
	logic [4:0]              shamt;

	assign shamt = b_i[4:0]; // low five bits only

	always_comb begin
		case (op_i)
			backend_ctrl_pkg::ALU_ADD: begin
				alu_res = a_i + b_i;
			end
			backend_ctrl_pkg::ALU_SUB: begin
				alu_res = a_i - b_i;
			end
			backend_ctrl_pkg::ALU_AND: begin
				alu_res = a_i & b_i;
			end
			backend_ctrl_pkg::ALU_OR: begin
				alu_res = a_i | b_i;
			end
			backend_ctrl_pkg::ALU_XOR: begin
				alu_res = a_i ^ b_i;
			end
			backend_ctrl_pkg::ALU_SLL: begin
				alu_res = a_i << shamt;
			end
			backend_ctrl_pkg::ALU_SRL: begin
				alu_res = a_i >> shamt;
			end
			backend_ctrl_pkg::ALU_SRA: begin
				alu_res = $signed(a_i) >>> shamt; // sign fill
			end
			backend_ctrl_pkg::ALU_SLT: begin
				alu_res = backend_data_pkg::word_t'($signed(a_i) < $signed(b_i));
			end
			backend_ctrl_pkg::ALU_SLTU: begin
				alu_res = backend_data_pkg::word_t'(a_i < b_i);
			end
			default: begin
				alu_res = '0; // unused encodings
			end
		endcase
	end

	// return address for calls
	assign link_res = pc_i + backend_data_pkg::word_t'(4);

	assign result_o = (wb_sel_i == backend_ctrl_pkg::WB_LINK) ? link_res : alu_res;

endmodule : exec_alu

/* hdl/forwarding_mux.sv */
`timescale 1ns/100ps

module forwarding_mux (
	input  backend_ctrl_pkg::fwd_stage_e sel_i,
	input  logic                         pipe_i,
	input  backend_data_pkg::fwd_src_t   src_i,
	input  backend_data_pkg::word_t      old_i,
	output backend_data_pkg::word_t      data_o
);

	// slot layout of src_i follows the pipe order m1, m2, wb
	always_comb begin
		case (sel_i)
			backend_ctrl_pkg::FWD_M1: begin
				data_o = src_i[pipe_i][0];
			end
			backend_ctrl_pkg::FWD_M2: begin
				data_o = src_i[pipe_i][1];
			end
			backend_ctrl_pkg::FWD_WB: begin
				data_o = src_i[pipe_i][2];
			end
			default: begin
				data_o = old_i; // no producer in flight
			end
		endcase
	end

endmodule : forwarding_mux

/* hdl/backend_data_pkg.sv */
`include "backend_settings.svh"

package backend_data_pkg;

	// one datapath word
	typedef logic [`BK_DATA_W-1:0] word_t;

	// register file index
	typedef logic [`BK_REG_ADDR_W-1:0] reg_addr_t;

	// external forwarding words
	// first index picks the pipe, second the slot
	// slot 0 is m1, slot 1 is m2, slot 2 is wb
	typedef word_t [`BK_PIPE_NUM-1:0][`BK_FWD_STAGE_NUM-1:0] fwd_src_t;

endpackage : backend_data_pkg

/* hdl/backend_ctrl_pkg.sv */
package backend_ctrl_pkg;

	// alu operation, shifts take b[4:0]
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8, // signed compare
		ALU_SLTU = 4'd9  // unsigned compare
	} alu_op_e;

	// which result goes to the register file
	typedef enum logic {
		WB_ALU  = 1'b0,
		WB_LINK = 1'b1  // pc + 4
	} wb_sel_e;

	// where an ex operand is taken from
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0, // register value
		FWD_M1   = 2'd1,
		FWD_M2   = 2'd2,
		FWD_WB   = 2'd3
	} fwd_stage_e;

endpackage : backend_ctrl_pkg

/* hdl/backend_settings.svh */
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// datapath word
`define BK_DATA_W 32

// architectural register number
`define BK_REG_ADDR_W 5

// pipes that feed the forwarding network
`define BK_PIPE_NUM 2

// forwarding slots per pipe (m1, m2, wb)
`define BK_FWD_STAGE_NUM 3

// ex, m1, m2, wb
`define BK_STAGE_NUM 4

`endif
